// ==== common/pwo_params_pkg.sv ====
//================================================
// Pointwise engine parameters
// Modulus, coefficient and memory word widths,
// polynomial word count, Barrett constants and
// pipeline latencies
//================================================

package pwo_params_pkg;

    // Coefficient arithmetic
    localparam int COEFF_W = 23;
    localparam logic [COEFF_W-1:0] PWO_Q = 23'd8380417;
    localparam int SLOT_W = 24;
    localparam int PROD_W = 46;

    // Memory word layout, four coefficients per word
    localparam int COEFFS_PER_WORD = 4;
    localparam int MEM_DATA_W = COEFFS_PER_WORD * SLOT_W;
    localparam int MEM_ADDR_W = 15;

    // One polynomial is 256 coefficients
    localparam int POLY_WORDS = 64;
    localparam int CNT_W = $clog2(POLY_WORDS);

    // Barrett reduction, M = floor(2^K / q)
    localparam int BARRETT_K = 46;
    localparam int BARRETT_M_W = 24;
    localparam logic [BARRETT_M_W-1:0] BARRETT_M = 24'd8396807;

    // Read enable to write enable distance
    // Memory read plus operand register plus lane stages
    localparam int LANE_LATENCY = 2;
    localparam int PIPE_LATENCY = 2 + LANE_LATENCY;

endpackage

// ==== common/pwo_types_pkg.sv ====
//================================================
// Pointwise engine types
// Operation encoding and the memory word union
//================================================

package pwo_types_pkg;

    // Operation select
    typedef enum logic [1:0] {
        PWO_NONE = 2'd0,
        PWO_PWM  = 2'd1,
        PWO_PWA  = 2'd2,
        PWO_PWS  = 2'd3
    } pwo_op_e;

    // One memory word
    // Flat view at the memory ports, slot view inside the lanes
    // Each slot holds a coefficient with a zero top bit
    typedef union packed {
        logic [pwo_params_pkg::MEM_DATA_W-1:0] flat;
        logic [pwo_params_pkg::COEFFS_PER_WORD-1:0][pwo_params_pkg::SLOT_W-1:0] slot;
    } mem_word_u;

endpackage

// ==== common/pwo_operand_if.sv ====
//================================================
// Operand bundle between the operand stage and
// the four arithmetic lanes
//================================================

interface pwo_operand_if;
    import pwo_types_pkg::*;

    // Operation for the word currently presented
    pwo_op_e op;

    // Operand a
    mem_word_u u_word;

    // Operand b, from memory or sampler
    mem_word_u v_word;

    // Accumulate operand, zero unless PWM with accumulate
    mem_word_u w_word;

    modport src (
        output op,
        output u_word,
        output v_word,
        output w_word
    );

    modport lane (
        input op,
        input u_word,
        input v_word,
        input w_word
    );

endinterface

// ==== pwo_datapath/pwo_lane.sv ====
//================================================
// Arithmetic lane for one coefficient slot
// Stage 1 forms the product, sum or difference
// Stage 2 reduces modulo q, with Barrett for
// products and accumulate
//================================================

module pwo_lane #(
    parameter int LANE = 0
) (
    input  logic                                clk,
    input  logic                                reset_n,
    pwo_operand_if.lane                         opnd,
    output logic [pwo_params_pkg::COEFF_W-1:0]  result_o
);
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;

    logic [COEFF_W-1:0]             u;
    logic [COEFF_W-1:0]             v;
    logic [PROD_W-1:0]              pre_d;
    logic [PROD_W-1:0]              pre_q;
    logic [COEFF_W-1:0]             w_q;
    pwo_op_e                        op_q;
    logic [PROD_W-1:0]              x;
    logic [PROD_W+BARRETT_M_W-1:0]  mq;
    logic [BARRETT_M_W-1:0]         qhat;
    logic [BARRETT_M_W+COEFF_W-1:0] qq;
    logic [SLOT_W-1:0]              r;
    logic [SLOT_W-1:0]              red;

    // Slot top bit is always zero, drop it
    assign u = opnd.u_word.slot[LANE][COEFF_W-1:0];
    assign v = opnd.v_word.slot[LANE][COEFF_W-1:0];

    // ==============================================
    // Stage 1
    // ==============================================
    always_comb begin
        case (opnd.op)
            PWO_PWM: pre_d = PROD_W'(u) * PROD_W'(v);
            PWO_PWA: pre_d = PROD_W'(u) + PROD_W'(v);
            // Adding q first keeps the difference positive
            PWO_PWS: pre_d = PROD_W'(u) + PROD_W'(PWO_Q) - PROD_W'(v);
            default: pre_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        pre_q <= pre_d;
        w_q   <= opnd.w_word.slot[LANE][COEFF_W-1:0];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_q <= PWO_NONE;
        end else begin
            op_q <= opnd.op;
        end
    end

    // ==============================================
    // Stage 2
    // ==============================================

    // u*v + w stays below q^2, well inside 2^46
    assign x = pre_q + PROD_W'(w_q);

    // Quotient estimate, remainder ends up below 2q
    assign mq   = (PROD_W + BARRETT_M_W)'(x) * (PROD_W + BARRETT_M_W)'(BARRETT_M);
    assign qhat = mq[BARRETT_K +: BARRETT_M_W];
    assign qq   = (BARRETT_M_W + COEFF_W)'(qhat) * (BARRETT_M_W + COEFF_W)'(PWO_Q);

    // Low bits suffice since the true remainder fits in a slot
    assign r = (op_q == PWO_PWM) ? x[SLOT_W-1:0] - qq[SLOT_W-1:0]
                                 : pre_q[SLOT_W-1:0];

    // Sums, differences and Barrett remainders all lie below 2q
    assign red = (r >= SLOT_W'(PWO_Q)) ? r - SLOT_W'(PWO_Q) : r;

    always_ff @(posedge clk) begin
        result_o <= red[COEFF_W-1:0];
    end

endmodule

// ==== pwo_datapath/pwo_operand_stage.sv ====
//================================================
// Operand stage
// Registers the three memory read words and
// selects the accumulate operand
//================================================

module pwo_operand_stage (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  pwo_types_pkg::pwo_op_e                 op_i,
    input  logic                                   acc_i,
    input  logic [pwo_params_pkg::MEM_DATA_W-1:0]  a_rd_data_i,
    input  logic [pwo_params_pkg::MEM_DATA_W-1:0]  b_rd_data_i,
    input  logic [pwo_params_pkg::MEM_DATA_W-1:0]  c_rd_data_i,
    pwo_operand_if.src                             opnd
);
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;

    mem_word_u a_q;
    mem_word_u b_q;
    mem_word_u c_q;
    pwo_op_e   op_q;
    logic      acc_q;
    logic      use_acc;

    // Read data, one cycle after it leaves the memories
    always_ff @(posedge clk) begin
        a_q.flat <= a_rd_data_i;
        b_q.flat <= b_rd_data_i;
        c_q.flat <= c_rd_data_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_q  <= PWO_NONE;
            acc_q <= 1'b0;
        end else begin
            op_q  <= op_i;
            acc_q <= acc_i;
        end
    end

    // Destination data is meaningful only for PWM with accumulate
    assign use_acc = (op_q == PWO_PWM) && acc_q;

    assign opnd.op     = op_q;
    assign opnd.u_word = a_q;
    assign opnd.v_word = b_q;
    assign opnd.w_word = use_acc ? c_q : '0;

endmodule

// ==== pwo_ctrl/pwo_ctrl.sv ====
//================================================
// Pointwise engine sequencer
// Walks the 64 words of a polynomial, issues reads,
// delays write strobes and addresses, and reports
// busy and done
//================================================

module pwo_ctrl (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  pwo_types_pkg::pwo_op_e                 pwo_mode_i,
    input  logic                                   pwo_enable_i,
    input  logic                                   accumulate_i,
    input  logic                                   sampler_valid_i,
    input  logic [pwo_params_pkg::MEM_ADDR_W-1:0]  a_base_addr_i,
    input  logic [pwo_params_pkg::MEM_ADDR_W-1:0]  b_base_addr_i,
    input  logic [pwo_params_pkg::MEM_ADDR_W-1:0]  c_base_addr_i,
    output logic                                   a_rd_en_o,
    output logic [pwo_params_pkg::MEM_ADDR_W-1:0]  a_rd_addr_o,
    output logic                                   b_rd_en_o,
    output logic [pwo_params_pkg::MEM_ADDR_W-1:0]  b_rd_addr_o,
    output logic                                   c_rd_en_o,
    output logic [pwo_params_pkg::MEM_ADDR_W-1:0]  c_rd_addr_o,
    output logic                                   wr_en_o,
    output logic [pwo_params_pkg::MEM_ADDR_W-1:0]  wr_addr_o,
    output pwo_types_pkg::pwo_op_e                 op_o,
    output logic                                   acc_o,
    output logic                                   busy_o,
    output logic                                   done_o
);
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } state_e;

    state_e                  state;
    logic [CNT_W-1:0]        word_cnt;
    pwo_op_e                 op_q;
    logic                    acc_q;
    logic                    done_q;
    logic [MEM_ADDR_W-1:0]   a_base;
    logic [MEM_ADDR_W-1:0]   b_base;
    logic [MEM_ADDR_W-1:0]   c_base;
    logic [MEM_ADDR_W-1:0]   word_offset;
    logic [PIPE_LATENCY-1:0] wr_vld;
    logic [MEM_ADDR_W-1:0]   wr_addr_pipe [PIPE_LATENCY];
    logic                    start;
    logic                    issue;
    logic                    last_word;
    logic                    last_wr;

    // ==============================================
    // Issue decode
    // ==============================================

    // Start only from idle with a real operation
    assign start = pwo_enable_i && (state == ST_IDLE) && (pwo_mode_i != PWO_NONE);

    // Sampler back-pressure stalls read issue only
    assign issue     = (state == ST_RUN) && sampler_valid_i;
    assign last_word = (word_cnt == CNT_W'(POLY_WORDS - 1));

    // Final write has nothing behind it in the delay line
    assign last_wr = (state == ST_DRAIN) && wr_vld[PIPE_LATENCY-1] &&
                     (wr_vld[PIPE_LATENCY-2:0] == '0);

    assign word_offset = MEM_ADDR_W'(word_cnt);

    // ==============================================
    // State, counter and strobe delay line
    // ==============================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
            op_q     <= PWO_NONE;
            acc_q    <= 1'b0;
            done_q   <= 1'b0;
            wr_vld   <= '0;
        end else begin
            done_q <= last_wr;
            wr_vld <= {wr_vld[PIPE_LATENCY-2:0], issue};

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_RUN;
                        word_cnt <= '0;
                        op_q     <= pwo_mode_i;
                        acc_q    <= accumulate_i;
                    end
                end
                ST_RUN: begin
                    if (issue) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (last_wr) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Base addresses and write address delay line
    always_ff @(posedge clk) begin
        if (start) begin
            a_base <= a_base_addr_i;
            b_base <= b_base_addr_i;
            c_base <= c_base_addr_i;
        end
        wr_addr_pipe[0] <= c_base + word_offset;
        for (int i = 1; i < PIPE_LATENCY; i++) begin
            wr_addr_pipe[i] <= wr_addr_pipe[i-1];
        end
    end

    // ==============================================
    // Outputs
    // ==============================================
    assign a_rd_en_o   = issue;
    assign a_rd_addr_o = a_base + word_offset;
    assign b_rd_en_o   = issue;
    assign b_rd_addr_o = b_base + word_offset;

    // Destination is only read when accumulating products
    assign c_rd_en_o   = issue && (op_q == PWO_PWM) && acc_q;
    assign c_rd_addr_o = c_base + word_offset;

    assign wr_en_o   = wr_vld[PIPE_LATENCY-1];
    assign wr_addr_o = wr_addr_pipe[PIPE_LATENCY-1];

    assign op_o   = op_q;
    assign acc_o  = acc_q;
    assign busy_o = (state != ST_IDLE);
    assign done_o = done_q;

endmodule

// ==== verilog/pwo_top.sv ====
//================================================
// Pointwise operation engine top level
// Sequencer, operand stage and four lanes,
// plain memory ports toward the system
//================================================

module pwo_top (
    input  logic                                   clk,
    input  logic                                   reset_n,

    // Control
    input  pwo_types_pkg::pwo_op_e                 pwo_mode_i,
    input  logic                                   pwo_enable_i,
    input  logic                                   accumulate_i,
    input  logic                                   sampler_valid_i,

    // Polynomial base addresses
    input  logic [pwo_params_pkg::MEM_ADDR_W-1:0]  a_base_addr_i,
    input  logic [pwo_params_pkg::MEM_ADDR_W-1:0]  b_base_addr_i,
    input  logic [pwo_params_pkg::MEM_ADDR_W-1:0]  c_base_addr_i,

    // Operand a memory
    output logic                                   pwm_a_rd_en_o,
    output logic [pwo_params_pkg::MEM_ADDR_W-1:0]  pwm_a_rd_addr_o,
    input  logic [pwo_params_pkg::MEM_DATA_W-1:0]  pwm_a_rd_data_i,

    // Operand b memory or sampler
    output logic                                   pwm_b_rd_en_o,
    output logic [pwo_params_pkg::MEM_ADDR_W-1:0]  pwm_b_rd_addr_o,
    input  logic [pwo_params_pkg::MEM_DATA_W-1:0]  pwm_b_rd_data_i,

    // Destination memory
    output logic                                   mem_rd_en_o,
    output logic [pwo_params_pkg::MEM_ADDR_W-1:0]  mem_rd_addr_o,
    input  logic [pwo_params_pkg::MEM_DATA_W-1:0]  mem_rd_data_i,
    output logic                                   mem_wr_en_o,
    output logic [pwo_params_pkg::MEM_ADDR_W-1:0]  mem_wr_addr_o,
    output logic [pwo_params_pkg::MEM_DATA_W-1:0]  mem_wr_data_o,

    // Status
    output logic                                   busy_o,
    output logic                                   done_o
);
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;

    pwo_op_e            op;
    logic               acc;
    logic [COEFF_W-1:0] lane_result [COEFFS_PER_WORD];
    mem_word_u          wr_word;

    pwo_operand_if opnd_if ();

    pwo_ctrl u_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .pwo_mode_i      (pwo_mode_i),
        .pwo_enable_i    (pwo_enable_i),
        .accumulate_i    (accumulate_i),
        .sampler_valid_i (sampler_valid_i),
        .a_base_addr_i   (a_base_addr_i),
        .b_base_addr_i   (b_base_addr_i),
        .c_base_addr_i   (c_base_addr_i),
        .a_rd_en_o       (pwm_a_rd_en_o),
        .a_rd_addr_o     (pwm_a_rd_addr_o),
        .b_rd_en_o       (pwm_b_rd_en_o),
        .b_rd_addr_o     (pwm_b_rd_addr_o),
        .c_rd_en_o       (mem_rd_en_o),
        .c_rd_addr_o     (mem_rd_addr_o),
        .wr_en_o         (mem_wr_en_o),
        .wr_addr_o       (mem_wr_addr_o),
        .op_o            (op),
        .acc_o           (acc),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    pwo_operand_stage u_operand_stage (
        .clk         (clk),
        .reset_n     (reset_n),
        .op_i        (op),
        .acc_i       (acc),
        .a_rd_data_i (pwm_a_rd_data_i),
        .b_rd_data_i (pwm_b_rd_data_i),
        .c_rd_data_i (mem_rd_data_i),
        .opnd        (opnd_if.src)
    );

    // One lane per coefficient slot, results packed back into a word
    for (genvar g = 0; g < COEFFS_PER_WORD; g++) begin : g_lane
        pwo_lane #(
            .LANE (g)
        ) u_lane (
            .clk      (clk),
            .reset_n  (reset_n),
            .opnd     (opnd_if.lane),
            .result_o (lane_result[g])
        );

        assign wr_word.slot[g] = SLOT_W'(lane_result[g]);
    end

    assign mem_wr_data_o = wr_word.flat;

endmodule

// ==== dv/pwo_tb.sv ====
//================================================
// Testbench for the pointwise operation engine
// Memory models, bus monitor, reference model and
// a table of operations applied in a loop
//================================================

module pwo_tb;
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;

    localparam int NUM_TESTS  = 7;
    localparam int WAIT_LIMIT = 2000;
    localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;

    logic                  clk;
    logic                  reset_n;
    pwo_op_e               mode;
    logic                  enable;
    logic                  acc;
    logic                  sampler_valid;
    logic [MEM_ADDR_W-1:0] a_base;
    logic [MEM_ADDR_W-1:0] b_base;
    logic [MEM_ADDR_W-1:0] c_base;
    logic                  a_rd_en;
    logic [MEM_ADDR_W-1:0] a_rd_addr;
    logic [MEM_DATA_W-1:0] a_rd_data = '0;
    logic                  b_rd_en;
    logic [MEM_ADDR_W-1:0] b_rd_addr;
    logic [MEM_DATA_W-1:0] b_rd_data = '0;
    logic                  c_rd_en;
    logic [MEM_ADDR_W-1:0] c_rd_addr;
    logic [MEM_DATA_W-1:0] c_rd_data = '0;
    logic                  wr_en;
    logic [MEM_ADDR_W-1:0] wr_addr;
    logic [MEM_DATA_W-1:0] wr_data;
    logic                  busy;
    logic                  done;

    logic [MEM_DATA_W-1:0] mem_a [MEM_DEPTH];
    logic [MEM_DATA_W-1:0] mem_b [MEM_DEPTH];
    logic [MEM_DATA_W-1:0] mem_c [MEM_DEPTH];
    mem_word_u             exp_word [POLY_WORDS];

    // Test table
    string                 tst_name [NUM_TESTS];
    pwo_op_e               tst_mode [NUM_TESTS];
    logic                  tst_acc  [NUM_TESTS];
    logic [15:0]           tst_gap  [NUM_TESTS];
    logic [MEM_ADDR_W-1:0] tst_a    [NUM_TESTS];
    logic [MEM_ADDR_W-1:0] tst_b    [NUM_TESTS];
    logic [MEM_ADDR_W-1:0] tst_c    [NUM_TESTS];

    // Monitor bookkeeping
    int                    cycle = 0;
    int                    rd_count;
    int                    wr_count;
    int                    done_count;
    int                    last_wr_cycle;
    int                    done_cycle;
    int                    rd_time_q [$];
    logic [MEM_ADDR_W-1:0] rd_off_q [$];
    string                 cur_name = "reset";
    logic [31:0]           rng_state = 32'd14864;

    pwo_top UUT (
        .clk             (clk),
        .reset_n         (reset_n),
        .pwo_mode_i      (mode),
        .pwo_enable_i    (enable),
        .accumulate_i    (acc),
        .sampler_valid_i (sampler_valid),
        .a_base_addr_i   (a_base),
        .b_base_addr_i   (b_base),
        .c_base_addr_i   (c_base),
        .pwm_a_rd_en_o   (a_rd_en),
        .pwm_a_rd_addr_o (a_rd_addr),
        .pwm_a_rd_data_i (a_rd_data),
        .pwm_b_rd_en_o   (b_rd_en),
        .pwm_b_rd_addr_o (b_rd_addr),
        .pwm_b_rd_data_i (b_rd_data),
        .mem_rd_en_o     (c_rd_en),
        .mem_rd_addr_o   (c_rd_addr),
        .mem_rd_data_i   (c_rd_data),
        .mem_wr_en_o     (wr_en),
        .mem_wr_addr_o   (wr_addr),
        .mem_wr_data_o   (wr_data),
        .busy_o          (busy),
        .done_o          (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================================
    // Helpers
    // ==============================================
    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(string what, logic [MEM_DATA_W-1:0] expected,
                            logic [MEM_DATA_W-1:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s expected %0h actual %0h", cur_name, what, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [31:0] next_random(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_coeff(output logic [COEFF_W-1:0] c);
        rng_state = next_random(rng_state);
        c = COEFF_W'(rng_state % {9'd0, PWO_Q});
    endtask

    // Expected coefficient straight from the modular arithmetic rules
    function automatic logic [COEFF_W-1:0] ref_coeff(pwo_op_e op, logic use_acc,
            logic [COEFF_W-1:0] a, logic [COEFF_W-1:0] b, logic [COEFF_W-1:0] c);
        longint unsigned q;
        longint unsigned w;
        longint unsigned r;
        q = 64'(PWO_Q);
        w = use_acc ? 64'(c) : 64'd0;
        case (op)
            PWO_PWM: r = (64'(a) * 64'(b) + w) % q;
            PWO_PWA: r = (64'(a) + 64'(b)) % q;
            PWO_PWS: r = (64'(a) + q - 64'(b)) % q;
            default: r = 64'd0;
        endcase
        return COEFF_W'(r);
    endfunction

    task automatic set_entry(int i, string name, pwo_op_e op, logic use_acc, logic [15:0] gap,
            logic [MEM_ADDR_W-1:0] ab, logic [MEM_ADDR_W-1:0] bb, logic [MEM_ADDR_W-1:0] cb);
        tst_name[i] = name;
        tst_mode[i] = op;
        tst_acc[i]  = use_acc;
        tst_gap[i]  = gap;
        tst_a[i]    = ab;
        tst_b[i]    = bb;
        tst_c[i]    = cb;
    endtask

    // Gap mask bit k gives sampler valid on the k-th cycle of the run
    task automatic load_table();
        set_entry(0, "pwm_plain",        PWO_PWM, 1'b0, 16'hFFFF, 15'h0000, 15'h0100, 15'h0200);
        set_entry(1, "pwm_accumulate",   PWO_PWM, 1'b1, 16'hFFFF, 15'h0400, 15'h0800, 15'h0C00);
        set_entry(2, "pwa",              PWO_PWA, 1'b0, 16'hFFFF, 15'h1000, 15'h1100, 15'h1200);
        set_entry(3, "pws",              PWO_PWS, 1'b0, 16'hFFFF, 15'h2000, 15'h2040, 15'h2080);
        set_entry(4, "pwm_sampler_gaps", PWO_PWM, 1'b0, 16'hB6D3, 15'h3000, 15'h3100, 15'h7FC0);
        set_entry(5, "pws_acc_ignored",  PWO_PWS, 1'b1, 16'h5A5A, 15'h4000, 15'h4100, 15'h4200);
        set_entry(6, "pwm_acc_gaps",     PWO_PWM, 1'b1, 16'h7E81, 15'h5000, 15'h5100, 15'h5200);
    endtask

    // Random operands below q, corner values in word 0
    task automatic fill_memories();
        mem_word_u          wa;
        mem_word_u          wb;
        mem_word_u          wc;
        logic [COEFF_W-1:0] ca;
        logic [COEFF_W-1:0] cb;
        logic [COEFF_W-1:0] cc;
        for (int i = 0; i < POLY_WORDS; i++) begin
            for (int s = 0; s < COEFFS_PER_WORD; s++) begin
                draw_coeff(ca);
                draw_coeff(cb);
                draw_coeff(cc);
                if (i == 0) begin
                    ca = (s == 0) ? '0 : (s == 3) ? COEFF_W'(1) : PWO_Q - 1'b1;
                    cb = (s == 2) ? '0 : PWO_Q - 1'b1;
                    cc = (s >= 2) ? PWO_Q - 1'b1 : cc;
                end
                wa.slot[s] = SLOT_W'(ca);
                wb.slot[s] = SLOT_W'(cb);
                wc.slot[s] = SLOT_W'(cc);
                exp_word[i].slot[s] = SLOT_W'(ref_coeff(mode, acc, ca, cb, cc));
            end
            mem_a[MEM_ADDR_W'(a_base + i)] = wa.flat;
            mem_b[MEM_ADDR_W'(b_base + i)] = wb.flat;
            mem_c[MEM_ADDR_W'(c_base + i)] = wc.flat;
        end
    endtask

    // ==============================================
    // Memory models and bus monitor
    // ==============================================
    always @(posedge clk) begin
        if (a_rd_en) a_rd_data <= mem_a[a_rd_addr];
        if (b_rd_en) b_rd_data <= mem_b[b_rd_addr];
        if (c_rd_en) c_rd_data <= mem_c[c_rd_addr];
        if (wr_en) mem_c[wr_addr] = wr_data;
    end

    always @(posedge clk) begin : bus_monitor
        logic [MEM_ADDR_W-1:0] off;
        logic [MEM_ADDR_W-1:0] wr_off;
        int                    rd_time;
        off = a_rd_addr - a_base;
        if (reset_n) begin
            if (a_rd_en) begin
                check_eq("read while sampler low", 1, sampler_valid);
                check_eq("b read enable", 1, b_rd_en);
                check_eq("b read address", b_base + off, b_rd_addr);
                check_eq("read order", rd_count, off);
                rd_time_q.push_back(cycle);
                rd_off_q.push_back(off);
                rd_count++;
            end
            check_eq("dest read enable", a_rd_en && mode == PWO_PWM && acc, c_rd_en);
            if (c_rd_en) check_eq("dest read address", c_base + off, c_rd_addr);
            if (wr_en) begin
                if (rd_time_q.size() == 0) begin
                    $display("Write with no outstanding read in test %s", cur_name);
                    abort_run();
                end
                rd_time = rd_time_q.pop_front();
                wr_off  = rd_off_q.pop_front();
                check_eq("write latency", PIPE_LATENCY, cycle - rd_time);
                check_eq("write address", c_base + wr_off, wr_addr);
                if (c_rd_en && c_rd_addr == wr_addr) begin
                    $display("Destination read and write hit one word in test %s", cur_name);
                    abort_run();
                end
                wr_count++;
                last_wr_cycle = cycle;
            end
            if (done) begin
                done_count++;
                done_cycle = cycle;
            end
        end
        cycle = cycle + 1;
    end

    // ==============================================
    // Test sequence
    // ==============================================
    task automatic run_test(int t);
        int k;
        cur_name      = tst_name[t];
        mode          = tst_mode[t];
        acc           = tst_acc[t];
        a_base        = tst_a[t];
        b_base        = tst_b[t];
        c_base        = tst_c[t];
        fill_memories();
        rd_count      = 0;
        wr_count      = 0;
        done_count    = 0;
        last_wr_cycle = -1;
        done_cycle    = -1;
        rd_time_q.delete();
        rd_off_q.delete();

        enable        = 1'b1;
        sampler_valid = tst_gap[t][0];
        @(negedge clk);
        enable = 1'b0;
        check_eq("busy after start", 1, busy);
        k = 1;
        while (!done) begin
            sampler_valid = tst_gap[t][k % 16];
            // A start pulse in mid run must be ignored
            enable = (k == 20);
            @(negedge clk);
            k++;
            if (k > WAIT_LIMIT) begin
                $display("Timeout waiting for done in test %s", cur_name);
                abort_run();
            end
        end
        sampler_valid = 1'b0;
        enable        = 1'b0;
        check_eq("busy falls with done", 0, busy);

        // Done must stay a single pulse
        repeat (3) begin
            @(negedge clk);
            check_eq("done after pulse", 0, done);
        end
        check_eq("read count", POLY_WORDS, rd_count);
        check_eq("write count", POLY_WORDS, wr_count);
        check_eq("done count", 1, done_count);
        check_eq("done after last write", last_wr_cycle + 1, done_cycle);
        for (int i = 0; i < POLY_WORDS; i++) begin
            check_eq($sformatf("word %0d", i), exp_word[i].flat,
                     mem_c[MEM_ADDR_W'(c_base + i)]);
        end
    endtask

    initial begin
        reset_n       = 1'b0;
        mode          = PWO_NONE;
        enable        = 1'b0;
        acc           = 1'b0;
        sampler_valid = 1'b0;
        a_base        = '0;
        b_base        = '0;
        c_base        = '0;
        load_table();
        repeat (5) @(negedge clk);
        reset_n = 1'b1;

        @(negedge clk);
        check_eq("a read enable", 0, a_rd_en);
        check_eq("b read enable", 0, b_rd_en);
        check_eq("dest read enable", 0, c_rd_en);
        check_eq("write enable", 0, wr_en);
        check_eq("busy", 0, busy);
        check_eq("done", 0, done);

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
common/pwo_params_pkg.sv
common/pwo_types_pkg.sv
common/pwo_operand_if.sv
pwo_datapath/pwo_lane.sv
pwo_datapath/pwo_operand_stage.sv
pwo_ctrl/pwo_ctrl.sv
verilog/pwo_top.sv
dv/pwo_tb.sv

// ==== Makefile ====
# Verilator flow for the pointwise operation engine

VERILATOR  ?= verilator
FILELIST   := verilog.f
TB_TOP     := pwo_tb
RTL_TOP    := pwo_top
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
BUILD_DIR  := obj_dir
LOG_FILE   := sim.log
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG_FILE) 2>&1
	@cat $(LOG_FILE)
	@grep -q "$(PASS_MSG)" $(LOG_FILE) || { echo "Simulation failed"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)
